//--- verilog/cpu_ctrl_config.svh
// Select and opcode widths are fixed at 4 bits; register code 0 never addresses a register
`ifndef CPU_CTRL_CONFIG_SVH
`define CPU_CTRL_CONFIG_SVH

// Width of the rst, A, B and C select fields
`define REG_SEL_W 4

// Select code for no register on a bus
`define SEL_NONE 4'd0

// B bus takes the immediate operand
`define SEL_IMM 4'd14

// C bus writes the program counter
`define SEL_PC 4'd15

// Opcode field in the high nibble of the instruction byte
`define OPC_W 4

`endif

//--- verilog/cpu_ctrl_pkg.sv
// Opcodes 0 and 15 are undefined; the control word packs 26 bits with pci as the MSB
`include "cpu_ctrl_config.svh"

package cpu_ctrl_pkg;

        typedef enum logic [`OPC_W-1:0] {
                OP_CLR   = 4'd1,
                OP_LOAD  = 4'd2,
                OP_STORE = 4'd3,
                OP_COPY  = 4'd4,
                OP_INCR  = 4'd5,
                OP_ADDI  = 4'd6,
                OP_ADDR  = 4'd7,
                OP_SUBI  = 4'd8,
                OP_SUBR  = 4'd9,
                OP_SHL   = 4'd10,
                OP_SHR   = 4'd11,
                OP_JPNZ  = 4'd12,
                OP_OR    = 4'd13,
                OP_ENDP  = 4'd14
        } opcode_e;

        typedef enum logic [3:0] {
                PH_IDLE,
                PH_FETCH,
                PH_FETCH_WAIT,
                PH_DECODE,
                PH_EXEC,
                PH_OPND_REQ,
                PH_OPND_WAIT,
                PH_WRITE,
                PH_JUMP
        } phase_e;

        typedef enum logic [3:0] {
                ALU_NONE,
                ALU_ABUS,   // Pass A bus through
                ALU_INCR,
                ALU_ADDI,
                ALU_ADDR,
                ALU_SUBI,
                ALU_SUBR,
                ALU_SHL,
                ALU_SHR,
                ALU_OR
        } alu_op_e;

        typedef enum logic [1:0] {
                MEM_NONE,
                MEM_DM_READ,
                MEM_DM_WRITE
        } mem_op_e;

        typedef struct packed {
                logic [`OPC_W-1:0]     opcode;
                logic [`REG_SEL_W-1:0] reg_sel;   // Register operand
        } opc_byte_t;

        typedef struct packed {
                logic [`REG_SEL_W-1:0] dst;
                logic [`REG_SEL_W-1:0] src;
        } opnd_byte_t;

        // Same byte seen as opcode byte or as operand byte
        typedef union packed {
                opc_byte_t  op;
                opnd_byte_t opnd;
        } instr_u;

        typedef struct packed {
                logic                  pci;
                logic [`REG_SEL_W-1:0] rst_sel;
                logic                  rst_pc;
                logic [`REG_SEL_W-1:0] a_sel;
                logic [`REG_SEL_W-1:0] b_sel;
                logic [`REG_SEL_W-1:0] c_sel;
                alu_op_e               alu_op;
                logic                  ifetch;
                mem_op_e               mem;
                logic                  branch;
        } ctrl_word_t;

endpackage

//--- verilog/instr_sequencer.sv
// One phase per clock and no stalls; instr must hold the opcode byte from DECODE through EXEC
`timescale 1ns/1ps

module instr_sequencer
        import cpu_ctrl_pkg::*;
(
        input  logic    clk,
        input  logic    rst,
        input  logic    start,
        input  instr_u  instr,
        input  logic    z_flag,
        output phase_e  phase,
        output opcode_e opcode,
        output logic    status
);

        phase_e phase_next;

        // Next phase from the current phase, instruction class and zero flag
        always_comb begin
                phase_next = PH_IDLE;
                case (phase)
                        PH_IDLE: begin
                                if (start) begin
                                        phase_next = PH_FETCH;
                                end
                        end
                        PH_FETCH: begin
                                phase_next = PH_FETCH_WAIT;
                        end
                        PH_FETCH_WAIT: begin
                                phase_next = PH_DECODE;
                        end
                        PH_DECODE: begin
                                case (instr.op.opcode)
                                        OP_CLR, OP_LOAD, OP_STORE,
                                        OP_INCR, OP_JPNZ, OP_ENDP: begin
                                                phase_next = PH_EXEC;
                                        end
                                        OP_COPY, OP_ADDI, OP_ADDR, OP_SUBI,
                                        OP_SUBR, OP_SHL, OP_SHR, OP_OR: begin
                                                phase_next = PH_OPND_REQ;
                                        end
                                        default: begin
                                                phase_next = PH_IDLE;   // Undefined opcode
                                        end
                                endcase
                        end
                        PH_EXEC: begin
                                if (opcode == OP_JPNZ && !z_flag) begin
                                        phase_next = PH_JUMP;
                                end else if (opcode == OP_ENDP) begin
                                        phase_next = PH_IDLE;
                                end else begin
                                        phase_next = PH_FETCH;
                                end
                        end
                        PH_OPND_REQ: begin
                                phase_next = PH_OPND_WAIT;
                        end
                        PH_OPND_WAIT: begin
                                phase_next = PH_WRITE;
                        end
                        PH_WRITE, PH_JUMP: begin
                                phase_next = PH_FETCH;
                        end
                        default: begin
                                phase_next = PH_IDLE;
                        end
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        phase  <= PH_IDLE;
                        status <= 1'b0;
                end else begin
                        phase <= phase_next;
                        if (phase == PH_IDLE && start) begin
                                status <= 1'b0;   // New run accepted
                        end else if (phase == PH_EXEC && opcode == OP_ENDP) begin
                                status <= 1'b1;
                        end
                end
        end

        // Latched at DECODE, read in EXEC and WRITE
        always_ff @(posedge clk) begin
                if (phase == PH_DECODE) begin
                        opcode <= opcode_e'(instr.op.opcode);
                end
        end

endmodule

//--- verilog/ctrl_decoder.sv
// Control word is registered and lags its phase by one cycle; instr is read live each phase
`timescale 1ns/1ps
`include "cpu_ctrl_config.svh"

module ctrl_decoder
        import cpu_ctrl_pkg::*;
(
        input  logic       clk,
        input  logic       rst,
        input  phase_e     phase,
        input  opcode_e    opcode,
        input  instr_u     instr,
        output ctrl_word_t ctrl
);

        localparam ctrl_word_t NONE_WORD = '{
                pci:     1'b0,
                rst_sel: `SEL_NONE,
                rst_pc:  1'b0,
                a_sel:   `SEL_NONE,
                b_sel:   `SEL_NONE,
                c_sel:   `SEL_NONE,
                alu_op:  ALU_NONE,
                ifetch:  1'b0,
                mem:     MEM_NONE,
                branch:  1'b0
        };

        ctrl_word_t ctrl_next;

        // ALU operation for the write phase of a two-byte instruction
        function automatic alu_op_e write_alu_op(input opcode_e op);
                alu_op_e res;
                case (op)
                        OP_COPY: res = ALU_ABUS;
                        OP_ADDI: res = ALU_ADDI;
                        OP_ADDR: res = ALU_ADDR;
                        OP_SUBI: res = ALU_SUBI;
                        OP_SUBR: res = ALU_SUBR;
                        OP_SHL:  res = ALU_SHL;
                        OP_SHR:  res = ALU_SHR;
                        OP_OR:   res = ALU_OR;
                        default: res = ALU_NONE;
                endcase
                return res;
        endfunction

        always_comb begin
                ctrl_next = NONE_WORD;
                case (phase)
                        PH_IDLE: begin
                                ctrl_next.rst_pc = 1'b1;
                        end
                        PH_FETCH, PH_OPND_REQ: begin
                                ctrl_next.ifetch = 1'b1;
                        end
                        PH_DECODE: begin
                                ctrl_next.pci = 1'b1;
                        end
                        PH_EXEC: begin
                                case (opcode)   // Opcode byte view
                                        OP_CLR:   ctrl_next.rst_sel = instr.op.reg_sel;
                                        OP_LOAD:  ctrl_next.mem = MEM_DM_READ;
                                        OP_STORE: ctrl_next.mem = MEM_DM_WRITE;
                                        OP_INCR: begin
                                                ctrl_next.a_sel  = instr.op.reg_sel;
                                                ctrl_next.c_sel  = instr.op.reg_sel;
                                                ctrl_next.alu_op = ALU_INCR;
                                        end
                                        default: ;   // JPNZ and ENDP drive nothing
                                endcase
                        end
                        PH_WRITE: begin
                                ctrl_next.pci    = 1'b1;
                                ctrl_next.alu_op = write_alu_op(opcode);
                                case (opcode)   // Operand byte view
                                        OP_COPY: begin
                                                ctrl_next.a_sel = instr.opnd.src;
                                                ctrl_next.c_sel = instr.opnd.dst;
                                        end
                                        OP_ADDI, OP_SUBI, OP_SHL, OP_SHR: begin
                                                ctrl_next.a_sel = instr.opnd.dst;
                                                ctrl_next.b_sel = `SEL_IMM;
                                                ctrl_next.c_sel = instr.opnd.dst;
                                        end
                                        OP_ADDR, OP_SUBR, OP_OR: begin
                                                ctrl_next.a_sel = instr.opnd.dst;
                                                ctrl_next.b_sel = instr.opnd.src;
                                                ctrl_next.c_sel = instr.opnd.dst;
                                        end
                                        default: ;
                                endcase
                        end
                        PH_JUMP: begin
                                ctrl_next.a_sel  = instr.op.reg_sel;   // Target held in register
                                ctrl_next.c_sel  = `SEL_PC;
                                ctrl_next.alu_op = ALU_ABUS;
                                ctrl_next.branch = 1'b1;
                        end
                        default: ;   // Wait phases
                endcase
        end

        always_ff @(posedge clk) begin
                if (rst) begin
                        ctrl <= NONE_WORD;
                        ctrl.rst_pc <= 1'b1;   // Idle word
                end else begin
                        ctrl <= ctrl_next;
                end
        end

endmodule

//--- verilog/cpu_ctrl_unit.sv
// No back-pressure; instr and z_flag must follow the ifetch timing of the control word
`timescale 1ns/1ps

module cpu_ctrl_unit
        import cpu_ctrl_pkg::*;
(
        input  logic       clk,
        input  logic       rst,
        input  logic       start,
        input  instr_u     instr,
        input  logic       z_flag,
        output ctrl_word_t ctrl,
        output logic       status
);

        phase_e  phase;
        opcode_e opcode;

        instr_sequencer u_instr_sequencer (
                .clk    (clk),
                .rst    (rst),
                .start  (start),
                .instr  (instr),
                .z_flag (z_flag),
                .phase  (phase),
                .opcode (opcode),
                .status (status)
        );

        ctrl_decoder u_ctrl_decoder (
                .clk    (clk),
                .rst    (rst),
                .phase  (phase),
                .opcode (opcode),
                .instr  (instr),
                .ctrl   (ctrl)
        );

endmodule

//--- verification/cpu_ctrl_properties.sv
// Bound onto ctrl_decoder; sees only the registered control word, not the phase
`timescale 1ns/1ps
`include "cpu_ctrl_config.svh"

module cpu_ctrl_properties
        import cpu_ctrl_pkg::*;
(
        input logic       clk,
        input logic       rst,
        input ctrl_word_t ctrl
);

        a_fetch_pci_apart: assert property (@(posedge clk) disable iff (rst)
                !(ctrl.ifetch && ctrl.pci))
                else $error("ifetch and pci high in the same cycle");

        a_branch_to_pc: assert property (@(posedge clk) disable iff (rst)
                ctrl.branch |-> ctrl.c_sel == `SEL_PC)
                else $error("branch without the PC on the C bus");

        a_mem_one_op: assert property (@(posedge clk) disable iff (rst)
                ctrl.mem != 2'b11)
                else $error("memory read and write requested together");

        a_reset_idle: assert property (@(posedge clk) rst |=> ctrl.rst_pc)
                else $error("rst_pc low after reset");

endmodule

//--- verification/cpu_ctrl_checker.sv
// Cycle model of phase, opcode and status; expects ctrl one cycle after the phase it belongs to
`timescale 1ns/1ps
`include "cpu_ctrl_config.svh"

module cpu_ctrl_checker
        import cpu_ctrl_pkg::*;
(
        input  logic       clk,
        input  logic       rst,
        input  logic       start,
        input  instr_u     instr,
        input  logic       z_flag,
        input  ctrl_word_t ctrl,
        input  logic       status,
        input  logic       report_req,
        output int         error_count
);

        localparam int N_BEH = 6;

        phase_e     m_phase;
        logic [3:0] m_opc;
        logic       m_status;
        ctrl_word_t exp_ctrl;
        int         exp_beh;
        logic       armed;
        int         total;
        int         checks [N_BEH];
        int         errors [N_BEH];

        function automatic string beh_name(input int b);
                case (b)
                        0:       return "reset";
                        1:       return "fetch";
                        2:       return "one_byte";
                        3:       return "two_byte";
                        4:       return "jpnz";
                        default: return "endp_idle";
                endcase
        endfunction

        function automatic int beh_of(input phase_e ph, input logic [3:0] op);
                case (ph)
                        PH_IDLE:  return 5;
                        PH_EXEC:  return (op == OP_JPNZ) ? 4 : (op == OP_ENDP) ? 5 : 2;
                        PH_WRITE: return 3;
                        PH_JUMP:  return 4;
                        default:  return 1;
                endcase
        endfunction

        function automatic ctrl_word_t expected_word(input phase_e ph, input logic [3:0] op,
                                                     input instr_u b);
                ctrl_word_t w;
                w        = '0;
                w.rst_pc = (ph == PH_IDLE);
                w.ifetch = (ph == PH_FETCH || ph == PH_OPND_REQ);
                w.pci    = (ph == PH_DECODE || ph == PH_WRITE);
                if (ph == PH_EXEC) begin
                        if (op == OP_CLR) w.rst_sel = b.op.reg_sel;
                        if (op == OP_LOAD) w.mem = MEM_DM_READ;
                        if (op == OP_STORE) w.mem = MEM_DM_WRITE;
                        if (op == OP_INCR) begin
                                w.a_sel  = b.op.reg_sel;
                                w.c_sel  = b.op.reg_sel;
                                w.alu_op = ALU_INCR;
                        end
                end
                if (ph == PH_WRITE) begin
                        w.a_sel = (op == OP_COPY) ? b.opnd.src : b.opnd.dst;
                        w.c_sel = b.opnd.dst;
                        if (op inside {OP_ADDI, OP_SUBI, OP_SHL, OP_SHR}) w.b_sel = `SEL_IMM;
                        if (op inside {OP_ADDR, OP_SUBR, OP_OR}) w.b_sel = b.opnd.src;
                        case (op)
                                OP_COPY: w.alu_op = ALU_ABUS;
                                OP_ADDI: w.alu_op = ALU_ADDI;
                                OP_ADDR: w.alu_op = ALU_ADDR;
                                OP_SUBI: w.alu_op = ALU_SUBI;
                                OP_SUBR: w.alu_op = ALU_SUBR;
                                OP_SHL:  w.alu_op = ALU_SHL;
                                OP_SHR:  w.alu_op = ALU_SHR;
                                default: w.alu_op = ALU_OR;
                        endcase
                end
                if (ph == PH_JUMP) begin
                        w.a_sel  = b.op.reg_sel;   // Jump target register
                        w.c_sel  = `SEL_PC;
                        w.alu_op = ALU_ABUS;
                        w.branch = 1'b1;
                end
                return w;
        endfunction

        always @(posedge clk) begin
                if (rst) begin
                        m_phase     = PH_IDLE;
                        m_status    = 1'b0;
                        exp_ctrl    = expected_word(PH_IDLE, 4'd0, '0);
                        exp_beh     = 0;
                        armed       = 1'b1;
                        error_count = 0;
                        for (int i = 0; i < N_BEH; i++) begin
                                checks[i] = 0;
                                errors[i] = 0;
                        end
                end else if (armed) begin
                        checks[exp_beh] = checks[exp_beh] + 1;
                        if (ctrl !== exp_ctrl) begin
                                $display("Fail %s expected %h actual %h",
                                         beh_name(exp_beh), exp_ctrl, ctrl);
                                errors[exp_beh] = errors[exp_beh] + 1;
                                error_count     = error_count + 1;
                        end
                        if (status !== m_status) begin
                                $display("Fail %s_status expected %b actual %b",
                                         beh_name(exp_beh), m_status, status);
                                errors[exp_beh] = errors[exp_beh] + 1;
                                error_count     = error_count + 1;
                        end
                        exp_ctrl = expected_word(m_phase, m_opc, instr);
                        exp_beh  = beh_of(m_phase, m_opc);
                        case (m_phase)
                                PH_IDLE: begin
                                        if (start) begin
                                                m_phase  = PH_FETCH;
                                                m_status = 1'b0;   // New run
                                        end
                                end
                                PH_FETCH:      m_phase = PH_FETCH_WAIT;
                                PH_FETCH_WAIT: m_phase = PH_DECODE;
                                PH_DECODE: begin
                                        m_opc = instr.op.opcode;
                                        if (m_opc inside {OP_CLR, OP_LOAD, OP_STORE, OP_INCR,
                                                          OP_JPNZ, OP_ENDP}) begin
                                                m_phase = PH_EXEC;
                                        end else if (m_opc == 4'd0 || m_opc == 4'd15) begin
                                                m_phase = PH_IDLE;
                                        end else begin
                                                m_phase = PH_OPND_REQ;
                                        end
                                end
                                PH_EXEC: begin
                                        if (m_opc == OP_ENDP) begin
                                                m_phase  = PH_IDLE;
                                                m_status = 1'b1;
                                        end else if (m_opc == OP_JPNZ && !z_flag) begin
                                                m_phase = PH_JUMP;
                                        end else begin
                                                m_phase = PH_FETCH;
                                        end
                                end
                                PH_OPND_REQ:  m_phase = PH_OPND_WAIT;
                                PH_OPND_WAIT: m_phase = PH_WRITE;
                                default:      m_phase = PH_FETCH;   // WRITE and JUMP
                        endcase
                        if (report_req) begin
                                armed = 1'b0;   // Counts are final from here
                                total = 0;
                                for (int i = 0; i < N_BEH; i++) begin
                                        if (checks[i] == 0) begin
                                                $display("Test %s was never exercised",
                                                         beh_name(i));
                                                error_count = error_count + 1;
                                        end
                                        $display("Test %s: %0d checks, %0d errors",
                                                 beh_name(i), checks[i], errors[i]);
                                        total = total + checks[i];
                                end
                                $display("Totals: %0d checks, %0d errors", total, error_count);
                        end
                end
        end

endmodule

//--- verification/cpu_ctrl_tb.sv
// Random 200-instruction program from a fixed seed; the last instruction is always ENDP
`timescale 1ns/1ps

module cpu_ctrl_tb
        import cpu_ctrl_pkg::*;
();

        localparam int N_INSTR     = 200;
        localparam int CLK_PERIOD  = 20;
        localparam int WATCHDOG_NS = N_INSTR * 6 * CLK_PERIOD * 3 / 2;

        logic        clk;
        logic        rst;
        logic        start;
        instr_u      instr;
        logic        z_flag;
        ctrl_word_t  ctrl;
        logic        status;
        logic        report_req;
        int          error_count;
        logic [31:0] rng = 32'h45a3;
        logic [3:0]  next_op;
        logic        need_opnd;
        int          n_instr;

        function automatic logic [31:0] xorshift(input logic [31:0] x);
                logic [31:0] y;
                y = x ^ (x << 13);
                y = y ^ (y >> 17);
                y = y ^ (y << 5);
                return y;
        endfunction

        // Mostly defined codes, ENDP rare, 0 and 15 now and then
        function automatic logic [3:0] pick_opcode(input logic [31:0] r);
                logic [3:0] op;
                if (r[7:0] < 8'd6) begin
                        op = {4{r[8]}};
                end else if (r[7:0] < 8'd10) begin
                        op = OP_ENDP;
                end else begin
                        op = 4'd1 + 4'(r[15:8] % 8'd13);   // CLR up to OR
                end
                return op;
        endfunction

        function automatic logic is_two_byte(input logic [3:0] op);
                return op inside {OP_COPY, OP_ADDI, OP_ADDR, OP_SUBI,
                                  OP_SUBR, OP_SHL, OP_SHR, OP_OR};
        endfunction

        cpu_ctrl_unit u_cpu_ctrl_unit (
                .clk    (clk),
                .rst    (rst),
                .start  (start),
                .instr  (instr),
                .z_flag (z_flag),
                .ctrl   (ctrl),
                .status (status)
        );

        cpu_ctrl_checker u_checker (
                .clk         (clk),
                .rst         (rst),
                .start       (start),
                .instr       (instr),
                .z_flag      (z_flag),
                .ctrl        (ctrl),
                .status      (status),
                .report_req  (report_req),
                .error_count (error_count)
        );

        bind ctrl_decoder cpu_ctrl_properties u_ctrl_props (
                .clk  (clk),
                .rst  (rst),
                .ctrl (ctrl)
        );

        initial begin
                clk = 1'b0;
                forever #(CLK_PERIOD / 2) clk = ~clk;
        end

        // Restart whenever the idle word shows, and feed a byte after each ifetch
        always @(posedge clk) begin
                if (!rst) begin
                        start <= ctrl.rst_pc && n_instr < N_INSTR;
                        if (ctrl.ifetch) begin
                                rng = xorshift(rng);
                                if (need_opnd) begin
                                        instr     <= rng[7:0];   // dst and src
                                        need_opnd <= 1'b0;
                                end else begin
                                        next_op = (n_instr == N_INSTR - 1) ? OP_ENDP
                                                                           : pick_opcode(rng);
                                        instr     <= {next_op, rng[19:16]};
                                        z_flag    <= rng[20];
                                        need_opnd <= is_two_byte(next_op);
                                        n_instr   <= n_instr + 1;
                                end
                        end
                end
        end

        initial begin
                rst        = 1'b1;
                start      = 1'b0;
                instr      = '0;
                z_flag     = 1'b0;
                report_req = 1'b0;
                need_opnd  = 1'b0;
                n_instr    = 0;
                repeat (2) @(posedge clk);
                rst <= 1'b0;
                while (!(n_instr == N_INSTR && status)) @(posedge clk);
                @(posedge clk);
                report_req <= 1'b1;
                repeat (2) @(posedge clk);
                if (error_count == 0) begin
                        $display("Simulation passed");
                end else begin
                        $display("Simulation failed");
                end
                $finish;
        end

        initial begin
                #(WATCHDOG_NS + 2 * CLK_PERIOD);
                $display("Timeout: the program never reached its final ENDP");
                $display("Simulation failed");
                $finish;
        end

endmodule

//--- tb.f
+incdir+verilog
verilog/cpu_ctrl_pkg.sv
verilog/instr_sequencer.sv
verilog/ctrl_decoder.sv
verilog/cpu_ctrl_unit.sv
verification/cpu_ctrl_properties.sv
verification/cpu_ctrl_checker.sv
verification/cpu_ctrl_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= cpu_ctrl_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(OBJ_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILELIST)) $(wildcard verilog/*.svh)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
